//--- acc_cpu_top.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/sram_bus_pkg.sv
hw/fetch_stage.sv
hw/exec_stage.sv
hw/sram_ctrl.sv
hw/acc_cpu_top.sv
verif/acc_cpu_properties.sv
verif/acc_cpu_tb.sv

//--- hw/acc_cpu_top.sv
`timescale 1ns/10ps
`include "mem_sys_cfg.svh"

module acc_cpu_top (
	input  logic                     clk,
	input  logic                     rst,
	output sram_bus_pkg::sram_pins_t sram,
	input  logic [`WORD_W-1:0]       sram_rdata,
	output logic [`WORD_W-1:0]       acc,
	output logic                     retire,
	output logic [`ADDR_W-1:0]       retire_pc,
	output logic                     halted
);

	logic                    if_req;
	logic [`ADDR_W-1:0]      if_addr;
	logic                    if_done;
	logic [`WORD_W-1:0]      if_rdata;
	cpu_isa_pkg::fetch_pkt_t pkt;
	logic                    stall;
	logic                    redirect;
	logic [`ADDR_W-1:0]      redirect_pc;
	sram_bus_pkg::exe_req_t  exe_req;
	logic                    exe_done;
	logic [`WORD_W-1:0]      exe_rdata;

	fetch_stage u_fetch (
		.clk(clk), .rst(rst),
		.if_req(if_req), .if_addr(if_addr), .if_done(if_done), .if_rdata(if_rdata),
		.pkt(pkt), .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc)
	);

	exec_stage u_exec (
		.clk(clk), .rst(rst),
		.pkt(pkt), .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.exe_req(exe_req), .exe_done(exe_done), .exe_rdata(exe_rdata),
		.acc(acc), .retire(retire), .retire_pc(retire_pc), .halted(halted)
	);

	sram_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.if_req(if_req), .if_addr(if_addr), .if_done(if_done), .if_rdata(if_rdata),
		.exe_req(exe_req), .exe_done(exe_done), .exe_rdata(exe_rdata),
		.sram(sram), .sram_rdata(sram_rdata)
	);

endmodule

//--- hw/cpu_isa_pkg.sv
`include "mem_sys_cfg.svh"

package cpu_isa_pkg;

	//////////////////////////////
	// Instruction encoding
	//////////////////////////////

	// Unlisted codes execute as a nop
	typedef enum logic [3:0] {
		op_nop   = 4'h0,
		op_ldi   = 4'h1,
		op_load  = 4'h2,
		op_add   = 4'h3,
		op_store = 4'h4,
		op_jmp   = 4'h5,
		op_halt  = 4'h6
	} opcode_e;

	// Operand is an immediate or an absolute word address
	typedef struct packed {
		opcode_e     op;
		logic [11:0] operand;
	} instr_t;

	// Hand-off slot between fetch and execute
	typedef struct packed {
		logic               valid;
		logic [`ADDR_W-1:0] pc;
		instr_t             instr;
	} fetch_pkt_t;

endpackage

//--- hw/exec_stage.sv
`timescale 1ns/10ps
`include "mem_sys_cfg.svh"

module exec_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_isa_pkg::fetch_pkt_t pkt,
	output logic                    stall,
	output logic                    redirect,
	output logic [`ADDR_W-1:0]      redirect_pc,
	output sram_bus_pkg::exe_req_t  exe_req,
	input  logic                    exe_done,
	input  logic [`WORD_W-1:0]      exe_rdata,
	output logic [`WORD_W-1:0]      acc,
	output logic                    retire,
	output logic [`ADDR_W-1:0]      retire_pc,
	output logic                    halted
);

	typedef enum logic [1:0] {
		ex_ready = 2'd0,
		ex_mem   = 2'd1,
		ex_halt  = 2'd2
	} exec_state_e;

	exec_state_e          state;
	cpu_isa_pkg::opcode_e op;
	logic                 take;
	logic                 mem_op;
	logic [`ADDR_W-1:0]   operand_ext;

	assign op          = pkt.instr.op;
	assign operand_ext = `ADDR_W'(pkt.instr.operand);
	assign mem_op      = (op == cpu_isa_pkg::op_load) || (op == cpu_isa_pkg::op_add) ||
	                     (op == cpu_isa_pkg::op_store);

	// Packet in the cycle after a jump is the wrong path
	assign take = (state == ex_ready) && pkt.valid && !redirect;

	// Memory ops and halt keep their packet in the slot
	assign stall = (state == ex_halt) || ((state == ex_mem) && !exe_done) ||
	               (take && (mem_op || (op == cpu_isa_pkg::op_halt)));

	assign halted = (state == ex_halt);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state          <= ex_ready;
			acc            <= '0;
			retire         <= 1'b0;
			redirect       <= 1'b0;
			exe_req.active <= 1'b0;
			exe_req.tag    <= 1'b0;
		end else begin
			retire   <= 1'b0;
			redirect <= 1'b0;
			case (state)
				ex_ready: begin
					if (take) begin
						retire_pc <= pkt.pc;
						case (op)
							cpu_isa_pkg::op_ldi: begin
								acc    <= operand_ext;
								retire <= 1'b1;
							end
							cpu_isa_pkg::op_load, cpu_isa_pkg::op_add, cpu_isa_pkg::op_store: begin
								exe_req.active <= 1'b1;
								exe_req.tag    <= ~exe_req.tag;
								exe_req.write  <= (op == cpu_isa_pkg::op_store);
								exe_req.addr   <= operand_ext;
								exe_req.wdata  <= acc;
								state          <= ex_mem;
							end
							cpu_isa_pkg::op_jmp: begin
								redirect    <= 1'b1;
								redirect_pc <= operand_ext;
								retire      <= 1'b1;
							end
							cpu_isa_pkg::op_halt: begin
								state  <= ex_halt;
								retire <= 1'b1;
							end
							default: retire <= 1'b1;
						endcase
					end
				end
				ex_mem: begin
					// Slot still holds the memory instruction
					if (exe_done) begin
						exe_req.active <= 1'b0;
						retire         <= 1'b1;
						state          <= ex_ready;
						if (op == cpu_isa_pkg::op_load)
							acc <= exe_rdata;
						else if (op == cpu_isa_pkg::op_add)
							acc <= acc + exe_rdata;
					end
				end
				default: state <= ex_halt;
			endcase
		end
	end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/10ps
`include "mem_sys_cfg.svh"

module fetch_stage (
	input  logic                    clk,
	input  logic                    rst,
	output logic                    if_req,
	output logic [`ADDR_W-1:0]      if_addr,
	input  logic                    if_done,
	input  logic [`WORD_W-1:0]      if_rdata,
	output cpu_isa_pkg::fetch_pkt_t pkt,
	input  logic                    stall,
	input  logic                    redirect,
	input  logic [`ADDR_W-1:0]      redirect_pc
);

	logic               run;
	logic [`ADDR_W-1:0] pc;
	logic               halt_held;
	logic               capture;

	// A held halt never leaves the slot, so stop touching the SRAM
	assign halt_held = pkt.valid && (pkt.instr.op == cpu_isa_pkg::op_halt);

	assign if_addr = pc;
	assign if_req  = run && !halt_held;

	// Slot is empty or execute takes it this cycle
	assign capture = if_req && if_done && (!pkt.valid || !stall);

	always_ff @(posedge clk) begin
		if (!rst) begin
			run       <= 1'b0;
			pc        <= `RESET_PC;
			pkt.valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (redirect) begin
				// Wrong-path word in the slot is dropped
				pc        <= redirect_pc;
				pkt.valid <= 1'b0;
			end else if (capture) begin
				pc        <= pc + `ADDR_W'(1);
				pkt.valid <= 1'b1;
				pkt.pc    <= pc;
				pkt.instr <= cpu_isa_pkg::instr_t'(if_rdata);
			end else if (!stall) begin
				pkt.valid <= 1'b0;
			end
		end
	end

endmodule

//--- hw/mem_sys_cfg.svh
`ifndef MEM_SYS_CFG_SVH
`define MEM_SYS_CFG_SVH

// Datapath and SRAM bus widths
`define WORD_W 16
`define ADDR_W 16

// First instruction fetched after reset
`define RESET_PC 16'h0000

// SRAM strobes are active low
`define SRAM_STROBE_ON  1'b0
`define SRAM_STROBE_OFF 1'b1

`endif

//--- hw/sram_bus_pkg.sv
`include "mem_sys_cfg.svh"

package sram_bus_pkg;

	// Three states per access, grouped by requester
	typedef enum logic [3:0] {
		st_idle    = 4'h0,
		st_exe_rd1 = 4'h1,
		st_exe_rd2 = 4'h2,
		st_exe_rd3 = 4'h3,
		st_if_rd1  = 4'h4,
		st_if_rd2  = 4'h5,
		st_if_rd3  = 4'h6,
		st_wr1     = 4'h7,
		st_wr2     = 4'h8,
		st_wr3     = 4'h9
	} ctrl_state_e;

	// New request whenever tag differs from the last completed one
	typedef struct packed {
		logic               active;
		logic               write;
		logic               tag;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
	} exe_req_t;

	// Pad side, the bidirectional buffer lives outside
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
		logic               drive;
		logic               en_n;
		logic               oe_n;
		logic               we_n;
	} sram_pins_t;

endpackage

//--- hw/sram_ctrl.sv
`timescale 1ns/10ps
`include "mem_sys_cfg.svh"

module sram_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     if_req,
	input  logic [`ADDR_W-1:0]       if_addr,
	output logic                     if_done,
	output logic [`WORD_W-1:0]       if_rdata,
	input  sram_bus_pkg::exe_req_t   exe_req,
	output logic                     exe_done,
	output logic [`WORD_W-1:0]       exe_rdata,
	output sram_bus_pkg::sram_pins_t sram,
	input  logic [`WORD_W-1:0]       sram_rdata
);

	sram_bus_pkg::ctrl_state_e state;

	logic [`ADDR_W-1:0] held_addr;
	logic               held_valid;
	logic               done_tag;
	logic               exe_pend;
	logic               if_cycle;
	logic               rd_strobe;
	logic               wr_cycle;

	//////////////////////////////
	// Completion flags
	//////////////////////////////

	// Word at held_addr is still in if_rdata
	assign if_done  = held_valid && (held_addr == if_addr);
	assign exe_done = (done_tag == exe_req.tag);
	assign exe_pend = exe_req.active && !exe_done;

	//////////////////////////////
	// Access sequencer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state      <= sram_bus_pkg::st_idle;
			held_addr  <= {`ADDR_W{1'b1}};
			held_valid <= 1'b0;
			done_tag   <= 1'b0;
		end else begin
			case (state)
				sram_bus_pkg::st_idle: begin
					// Execute wins over fetch
					if (exe_pend)
						state <= exe_req.write ? sram_bus_pkg::st_wr1 : sram_bus_pkg::st_exe_rd1;
					else if (if_req && !if_done)
						state <= sram_bus_pkg::st_if_rd1;
				end
				sram_bus_pkg::st_exe_rd1: state <= sram_bus_pkg::st_exe_rd2;
				sram_bus_pkg::st_exe_rd2: state <= sram_bus_pkg::st_exe_rd3;
				sram_bus_pkg::st_exe_rd3: begin
					exe_rdata <= sram_rdata;
					done_tag  <= exe_req.tag;
					state     <= sram_bus_pkg::st_idle;
				end
				sram_bus_pkg::st_if_rd1: begin
					held_valid <= 1'b0;
					state      <= sram_bus_pkg::st_if_rd2;
				end
				sram_bus_pkg::st_if_rd2: state <= sram_bus_pkg::st_if_rd3;
				sram_bus_pkg::st_if_rd3: begin
					if_rdata   <= sram_rdata;
					held_addr  <= if_addr;
					held_valid <= 1'b1;
					state      <= sram_bus_pkg::st_idle;
				end
				sram_bus_pkg::st_wr1: state <= sram_bus_pkg::st_wr2;
				sram_bus_pkg::st_wr2: state <= sram_bus_pkg::st_wr3;
				sram_bus_pkg::st_wr3: begin
					done_tag <= exe_req.tag;
					// Store over the held instruction makes it stale
					if (held_addr == exe_req.addr)
						held_valid <= 1'b0;
					state <= sram_bus_pkg::st_idle;
				end
				default: state <= sram_bus_pkg::st_idle;
			endcase
		end
	end

	//////////////////////////////
	// Pin decode
	//////////////////////////////

	assign if_cycle  = (state == sram_bus_pkg::st_if_rd1) || (state == sram_bus_pkg::st_if_rd2) ||
	                   (state == sram_bus_pkg::st_if_rd3);
	assign rd_strobe = (state == sram_bus_pkg::st_exe_rd2) || (state == sram_bus_pkg::st_exe_rd3) ||
	                   (state == sram_bus_pkg::st_if_rd2) || (state == sram_bus_pkg::st_if_rd3);
	assign wr_cycle  = (state == sram_bus_pkg::st_wr1) || (state == sram_bus_pkg::st_wr2) ||
	                   (state == sram_bus_pkg::st_wr3);

	always_comb begin
		// A fetch already under way keeps its own address
		sram.addr  = (exe_req.active && !if_cycle) ? exe_req.addr : if_addr;
		sram.wdata = exe_req.wdata;
		sram.drive = wr_cycle;
		sram.en_n  = (state == sram_bus_pkg::st_idle) ? `SRAM_STROBE_OFF : `SRAM_STROBE_ON;
		sram.oe_n  = rd_strobe ? `SRAM_STROBE_ON : `SRAM_STROBE_OFF;
		sram.we_n  = (state == sram_bus_pkg::st_wr2) ? `SRAM_STROBE_ON : `SRAM_STROBE_OFF;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the accumulator CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module acc_cpu_tb -f acc_cpu_top.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vacc_cpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$log"; then
	exit 0
fi
exit 1

//--- verif/acc_cpu_properties.sv
`timescale 1ns/10ps

module acc_cpu_properties (
	input logic                     clk,
	input logic                     rst,
	input sram_bus_pkg::sram_pins_t sram
);

	// Read and write strobes never overlap
	a_oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(!sram.oe_n && !sram.we_n))
		else $error("oe_n and we_n are low together");

	// Single-cycle write pulse
	a_we_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		!sram.we_n |=> sram.we_n)
		else $error("we_n stayed low for more than one cycle");

	a_we_with_drive: assert property (@(posedge clk) disable iff (!rst)
		!sram.we_n |-> sram.drive)
		else $error("we_n is low while the write data bus is not driven");

	a_disabled_quiet: assert property (@(posedge clk) disable iff (!rst)
		sram.en_n |-> (sram.oe_n && sram.we_n))
		else $error("oe_n or we_n is low while en_n is high");

endmodule

//--- verif/acc_cpu_tb.sv
`timescale 1ns/10ps
`include "mem_sys_cfg.svh"

module acc_cpu_tb;

	localparam int N_PROGS   = 3;
	localparam int PROG_LEN  = 40;
	localparam int RESET_CYC = 8;
	localparam int DRAIN_CYC = 10;
	// About 12 cycles per instruction at worst, halt included
	localparam int CYCLE_LIMIT = N_PROGS * (PROG_LEN + 1) * 12 +
	                             N_PROGS * (RESET_CYC + DRAIN_CYC + 6);

	logic                     clk;
	logic                     rst;
	sram_bus_pkg::sram_pins_t sram;
	logic [`WORD_W-1:0]       sram_rdata;
	logic [`WORD_W-1:0]       acc;
	logic                     retire;
	logic [`ADDR_W-1:0]       retire_pc;
	logic                     halted;

	logic [15:0] mem [0:4095];
	logic [15:0] ref_mem [0:4095];
	bit          skipped [0:4095];
	logic [15:0] exp_pc [$];
	logic [15:0] exp_acc [$];
	logic [15:0] exp_wa [$];
	logic [15:0] exp_wd [$];
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          ret_idx;
	int          wr_idx;

	acc_cpu_top dut0 (
		.clk(clk), .rst(rst), .sram(sram), .sram_rdata(sram_rdata),
		.acc(acc), .retire(retire), .retire_pc(retire_pc), .halted(halted)
	);

	bind sram_ctrl acc_cpu_properties u_props (
		.clk(clk), .rst(rst), .sram(sram)
	);

	// Pad side of the SRAM returns ones when not read
	assign sram_rdata = (!sram.oe_n && !sram.en_n) ? mem[sram.addr[11:0]] : '1;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("ERROR: run did not halt within the cycle limit of %0d cycles", CYCLE_LIMIT);
			$display("checks=%0d errors=%0d timeout=1", checks, errors);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [15:0] expected,
	                          input logic [15:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////
	// Program generator
	//////////////////////////////

	task automatic gen_program();
		int          i;
		int          r;
		int          t;
		logic [3:0]  op;
		logic [11:0] opnd;
		for (i = 0; i < 4096; i++)
			ref_mem[i] = 16'(i) ^ 16'hc3a5;
		for (i = 'h800; i < 'h900; i++)
			ref_mem[i] = 16'($urandom);
		for (i = 0; i < PROG_LEN - 1; i++) begin
			r = int'($urandom % 8);
			case (r)
				0: op = cpu_isa_pkg::op_nop;
				1: op = cpu_isa_pkg::op_ldi;
				2: op = cpu_isa_pkg::op_load;
				3: op = cpu_isa_pkg::op_add;
				4: op = cpu_isa_pkg::op_store;
				5: op = cpu_isa_pkg::op_jmp;
				// Codes outside the ISA run as nop
				default: op = 4'(7 + $urandom % 9);
			endcase
			opnd = 12'($urandom);
			if ((op == cpu_isa_pkg::op_load) || (op == cpu_isa_pkg::op_add) ||
			    (op == cpu_isa_pkg::op_store)) begin
				opnd = {4'h8, opnd[7:0]};
			end else if (op == cpu_isa_pkg::op_jmp) begin
				t = i + 2 + int'($urandom % 3);
				opnd = (t > PROG_LEN - 1) ? 12'(PROG_LEN - 1) : 12'(t);
			end
			ref_mem[i] = {op, opnd};
		end
		ref_mem[PROG_LEN - 1] = {cpu_isa_pkg::op_halt, 12'h000};
		for (i = 0; i < 4096; i++)
			mem[i] = ref_mem[i];
	endtask

	//////////////////////////////
	// ISA reference model
	//////////////////////////////

	task automatic run_model();
		int          pc;
		int          opnd;
		int          k;
		logic [3:0]  op;
		logic [15:0] a;
		pc = 0;
		a  = 16'h0000;
		exp_pc.delete();
		exp_acc.delete();
		exp_wa.delete();
		exp_wd.delete();
		for (k = 0; k < 4096; k++)
			skipped[k] = 1'b0;
		forever begin
			op   = ref_mem[pc][15:12];
			opnd = int'(ref_mem[pc][11:0]);
			case (op)
				cpu_isa_pkg::op_ldi:  a = {4'h0, ref_mem[pc][11:0]};
				cpu_isa_pkg::op_load: a = ref_mem[opnd];
				cpu_isa_pkg::op_add:  a = a + ref_mem[opnd];
				cpu_isa_pkg::op_store: begin
					ref_mem[opnd] = a;
					exp_wa.push_back(16'(opnd));
					exp_wd.push_back(a);
				end
				default: ;
			endcase
			exp_pc.push_back(16'(pc));
			exp_acc.push_back(a);
			if (op == cpu_isa_pkg::op_halt)
				break;
			if (op == cpu_isa_pkg::op_jmp) begin
				for (k = pc + 1; k < opnd; k++)
					skipped[k] = 1'b1;
				pc = opnd;
			end else begin
				pc++;
			end
		end
	endtask

	task automatic apply_reset();
		int i;
		@(posedge clk);
		#1 rst = 1'b0;
		for (i = 0; i < RESET_CYC; i++) begin
			@(negedge clk);
			// No reset edge has been seen before the first one
			if (i > 0) begin
				check_word("sram.en_n", 16'h1, 16'(sram.en_n));
				check_word("sram.oe_n", 16'h1, 16'(sram.oe_n));
				check_word("sram.we_n", 16'h1, 16'(sram.we_n));
				check_word("sram.drive", 16'h0, 16'(sram.drive));
				check_word("retire", 16'h0, 16'(retire));
				check_word("halted", 16'h0, 16'(halted));
			end
		end
		@(posedge clk);
		#1 rst = 1'b1;
		// First fetch takes at least four cycles
		repeat (4) begin
			@(negedge clk);
			check_word("retire", 16'h0, 16'(retire));
		end
	endtask

	task automatic run_program();
		int i;
		ret_idx = 0;
		wr_idx  = 0;
		do begin
			@(negedge clk);
			if (retire) begin
				if (ret_idx < exp_pc.size()) begin
					check_word("retire_pc", exp_pc[ret_idx], retire_pc);
					check_word("acc", exp_acc[ret_idx], acc);
				end else begin
					$display("ERROR: t=%0t retire pulse beyond the model's instruction count", $time);
					errors++;
				end
				checks++;
				assert (!skipped[retire_pc[11:0]])
				else begin
					$display("ERROR: t=%0t pc %h retired although a jump skipped it", $time, retire_pc);
					errors++;
				end
				ret_idx++;
			end
			if (!sram.we_n) begin
				if (wr_idx < exp_wa.size()) begin
					check_word("sram.addr", exp_wa[wr_idx], sram.addr);
					check_word("sram.wdata", exp_wd[wr_idx], sram.wdata);
				end else begin
					$display("ERROR: t=%0t SRAM write that the model does not expect", $time);
					errors++;
				end
				mem[sram.addr[11:0]] = sram.wdata;
				wr_idx++;
			end
		end while (!halted);
		// Halted core stays off the bus
		repeat (DRAIN_CYC) begin
			@(negedge clk);
			check_word("retire", 16'h0, 16'(retire));
			check_word("sram.en_n", 16'h1, 16'(sram.en_n));
			check_word("halted", 16'h1, 16'(halted));
		end
		check_word("retire count", 16'(exp_pc.size()), 16'(ret_idx));
		check_word("write count", 16'(exp_wa.size()), 16'(wr_idx));
		for (i = 0; i < 4096; i++)
			check_word($sformatf("mem[%03h]", i), ref_mem[i], mem[i]);
	endtask

	initial begin
		int p;
		rst = 1'b0;
		void'($urandom(32'hd485));
		for (p = 0; p < N_PROGS; p++) begin
			gen_program();
			run_model();
			apply_reset();
			run_program();
		end
		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
